// ==== list.f ====
verilog/dev_pkg.sv
verilog/spi_shifter.sv
verilog/spi_axil_regs.sv
verilog/core2axi_bridge.sv
verilog/clint_timer.sv
verilog/dev_bus_ctrl.sv
verilog/dev_subsystem.sv
tb/tb_dev_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the device subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module tb_dev_subsystem -f list.f -Mdir "$OBJ" -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    echo "Failure reported, see $LOG"
    exit 1
fi

if ! grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0

// ==== tb/tb_dev_subsystem.sv ====
`timescale 1ns/1ps

module tb_dev_subsystem import dev_pkg::*; ();

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int RST_STRETCH    = 8;
    localparam int SPI_CLK_DIV    = 4;
    localparam int IRQ_N          = 40;     // mtimecmp value for the interrupt test
    localparam int MTIME_GAP      = 5;      // Idle cycles between the two mtime reads
    localparam int ACCESS_CYCLES  = 8;      // Upper bound for one bus access
    localparam int BUS_WAIT_LIMIT = 32;     // Cycles to wait for ready
    localparam int SPI_POLL_LIMIT = 16;

    // Test lengths in cycles and a run limit with half again as margin
    localparam int T_RESET    = RESET_CYCLES + RST_STRETCH + 8;
    localparam int T_TIMER    = 6 * ACCESS_CYCLES + MTIME_GAP;
    localparam int T_IRQ      = 5 * ACCESS_CYCLES + IRQ_N + 3;
    localparam int T_SPI      = 8 * ACCESS_CYCLES + 8 * SPI_CLK_DIV;
    localparam int T_UNMAPPED = 2 * ACCESS_CYCLES;
    localparam int TIMEOUT_CYCLES = (T_RESET + T_TIMER + T_IRQ + T_SPI + T_UNMAPPED) * 3 / 2;

    logic   clk          = 1'b0;
    logic   usr_reset    = 1'b1;
    logic   dev_strobe_i = 1'b0;
    xword_t dev_addr_i   = '0;
    logic   dev_we_i     = 1'b0;
    xbe_t   dev_be_i     = '0;
    xword_t dev_din_i    = '0;
    logic   spi_miso_i   = 1'b0;
    xword_t dev_dout_o;
    logic   dev_ready_o, spi_mosi_o, spi_sck_o, spi_ss_o, tmr_irq_o, sft_irq_o;

    logic [31:0] lfsr_state  = 32'hc46f;
    logic        reset_check = 1'b0;    // Window where outputs must hold reset values
    logic [5:0]  reset_outs;            // Packed as ready tmr sft ss sck mosi
    int          cycle_count = 0;
    int          errors = 0, errors_at_start = 0;
    int          tests_passed = 0, tests_failed = 0;
    string       test_name = "none";

    // Result of the last bus access
    xword_t      last_rdata;
    int          last_latency;
    time         last_strobe_t;         // Edge where the strobe was sampled

    // SD card model state
    logic [7:0]  card_tx = '0, card_shift = '0, card_rx = '0;
    int          card_bits = 0;
    logic        sck_prev = 1'b0, ss_prev = 1'b1;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dev_subsystem #(.RST_STRETCH(RST_STRETCH), .SPI_CLK_DIV(SPI_CLK_DIV)) dut (
        .clk(clk), .usr_reset(usr_reset),
        .dev_strobe_i(dev_strobe_i), .dev_addr_i(dev_addr_i), .dev_we_i(dev_we_i),
        .dev_be_i(dev_be_i), .dev_din_i(dev_din_i),
        .dev_dout_o(dev_dout_o), .dev_ready_o(dev_ready_o),
        .spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i),
        .spi_sck_o(spi_sck_o), .spi_ss_o(spi_ss_o),
        .tmr_irq_o(tmr_irq_o), .sft_irq_o(sft_irq_o)
    );

    // --------------------
    // Assertions
    // --------------------
    assign reset_outs = {dev_ready_o, tmr_irq_o, sft_irq_o, spi_ss_o, spi_sck_o, spi_mosi_o};

    assert property (@(posedge clk) reset_check |-> (reset_outs == 6'b000100))
    else begin
        $display("CHECK FAILED %s reset outputs: expected %b actual %b",
                 test_name, 6'b000100, $sampled(reset_outs));
        errors++;
    end

    assert property (@(posedge clk) dev_ready_o |=> !dev_ready_o)
    else begin
        $display("%s: ready stayed high for more than one cycle", test_name);
        errors++;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, test %s did not finish",
                     TIMEOUT_CYCLES, test_name);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------
    // SD card model
    // --------------------
    always @(posedge clk) begin
        sck_prev <= spi_sck_o;
        ss_prev  <= spi_ss_o;
        if (ss_prev && !spi_ss_o) begin                 // Card selected so the reply byte loads
            card_shift <= card_tx;
            spi_miso_i <= card_tx[7];                   // MSB ready before first rise
            card_rx    <= '0;
            card_bits  <= 0;
        end else if (!spi_ss_o && !sck_prev && spi_sck_o) begin
            card_rx    <= {card_rx[6:0], spi_mosi_o};   // MOSI taken on rising SCK
            card_shift <= {card_shift[6:0], 1'b0};
            spi_miso_i <= card_shift[6];                // DUT already sampled this bit
            card_bits  <= card_bits + 1;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic xword_t merge_bytes(input xword_t old_w, input xword_t new_w,
                                           input xbe_t be);
        xword_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                res[8 * i +: 8] = new_w[8 * i +: 8];
        end
        return res;
    endfunction

    function automatic xword_t clint_addr(input logic [11:0] ofs);
        return {REGION_CLINT, 12'h000, ofs};
    endfunction

    function automatic xword_t spi_addr(input logic [11:0] ofs);
        return {REGION_SPI, 12'h000, ofs};
    endfunction

    task automatic check_value(input string what, input xword_t exp, input xword_t act);
        assert (act === exp)
        else begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond)
        else begin
            $display("%s: %s", test_name, what);
            errors++;
        end
    endtask

    // One strobe and a wait for ready with latency counted from the strobe edge
    task automatic bus_access(input xword_t addr, input logic we, input xbe_t be,
                              input xword_t wdata);
        int waited;
        @(posedge clk);
        dev_strobe_i <= 1'b1;
        dev_addr_i   <= addr;
        dev_we_i     <= we;
        dev_be_i     <= be;
        dev_din_i    <= wdata;
        @(posedge clk);
        last_strobe_t = $time;
        dev_strobe_i <= 1'b0;
        waited       = 0;
        last_latency = -1;
        last_rdata   = '0;
        while (last_latency < 0 && waited < BUS_WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            if (dev_ready_o) begin
                last_latency = waited;
                last_rdata   = dev_dout_o;
            end
        end
        expect_true(last_latency >= 0,
                    $sformatf("no ready for address %h within %0d cycles", addr, waited));
    endtask

    task automatic open_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic close_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic reset_state();
        repeat (2) @(posedge clk);
        reset_check <= 1'b1;
        repeat (RESET_CYCLES - 2) @(posedge clk);
        usr_reset <= 1'b0;
        repeat (RST_STRETCH) @(posedge clk);    // Stretched reset still active
        reset_check <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("ready after reset", 0, 32'(dev_ready_o));
        check_value("tmr_irq after reset", 0, 32'(tmr_irq_o));
        check_value("sft_irq after reset", 0, 32'(sft_irq_o));
        check_value("ss after reset", 1, 32'(spi_ss_o));
    endtask

    task automatic timer_access();
        xword_t cmp_full, cmp_part, t1, t2;
        xbe_t   be;
        time    t1_at;
        int     gap;
        cmp_full = random_bits(32);
        cmp_part = random_bits(32);
        be       = xbe_t'(random_bits(4));
        bus_access(clint_addr(CLINT_CMP_HI_OFS), 1'b0, '0, '0);
        check_value("mtimecmp high reset", 32'hFFFF_FFFF, last_rdata);
        check_value("read latency", 2, last_latency);
        bus_access(clint_addr(CLINT_CMP_LO_OFS), 1'b1, 4'hF, cmp_full);
        check_value("write latency", 2, last_latency);
        bus_access(clint_addr(CLINT_CMP_LO_OFS), 1'b1, be, cmp_part);
        bus_access(clint_addr(CLINT_CMP_LO_OFS), 1'b0, '0, '0);
        check_value("mtimecmp byte merge", merge_bytes(cmp_full, cmp_part, be), last_rdata);
        bus_access(clint_addr(CLINT_TIME_LO_OFS), 1'b0, '0, '0);
        t1    = last_rdata;
        t1_at = last_strobe_t;
        repeat (MTIME_GAP) @(posedge clk);
        bus_access(clint_addr(CLINT_TIME_LO_OFS), 1'b0, '0, '0);
        t2  = last_rdata;
        gap = int'((last_strobe_t - t1_at) / CLK_PERIOD);
        expect_true(t2 > t1 && (t2 - t1) >= xword_t'(gap),
                    $sformatf("mtime went from %0d to %0d over %0d cycles", t1, t2, gap));
    endtask

    task automatic irq_lines();
        time t_zero;
        int  waited, irq_cycles;
        bus_access(clint_addr(CLINT_CMP_LO_OFS), 1'b1, 4'hF, IRQ_N);
        bus_access(clint_addr(CLINT_TIME_LO_OFS), 1'b1, 4'hF, '0);
        t_zero = last_strobe_t;                 // mtime is 0 after this edge
        bus_access(clint_addr(CLINT_CMP_HI_OFS), 1'b1, 4'hF, '0);
        waited = 0;
        while (!tmr_irq_o && waited < IRQ_N + 8) begin
            @(posedge clk);
            waited++;
        end
        irq_cycles = int'(($time - t_zero) / CLK_PERIOD);
        expect_true(tmr_irq_o, $sformatf("timer interrupt did not rise, mtimecmp %0d", IRQ_N));
        expect_true(irq_cycles > IRQ_N && irq_cycles <= IRQ_N + 3,
                    $sformatf("timer interrupt rose %0d cycles after mtime reset, limit %0d",
                              irq_cycles, IRQ_N));
        bus_access(clint_addr(CLINT_MSIP_OFS), 1'b1, 4'h1, 32'h1);
        check_value("sft_irq after msip set", 1, 32'(sft_irq_o));
        bus_access(clint_addr(CLINT_MSIP_OFS), 1'b1, 4'h1, 32'h0);
        check_value("sft_irq after msip clear", 0, 32'(sft_irq_o));
    endtask

    task automatic spi_transfer();
        logic [7:0] tx_byte;
        logic       busy;
        int         polls;
        card_tx = 8'(random_bits(8));
        tx_byte = 8'(random_bits(8));
        bus_access(spi_addr(SPI_CTRL_OFS), 1'b1, 4'hF, '0);
        check_value("ss after select", 0, 32'(spi_ss_o));
        bus_access(spi_addr(SPI_CTRL_OFS), 1'b0, '0, '0);
        check_value("control readback", 0, last_rdata);
        bus_access(spi_addr(SPI_TXD_OFS), 1'b1, 4'hF, 32'(tx_byte));
        bus_access(spi_addr(SPI_STAT_OFS), 1'b0, '0, '0);
        check_value("busy after transmit write", 1, last_rdata);
        busy  = last_rdata[0];
        polls = 0;
        while (busy && polls < SPI_POLL_LIMIT) begin
            bus_access(spi_addr(SPI_STAT_OFS), 1'b0, '0, '0);
            busy = last_rdata[0];
            polls++;
        end
        expect_true(!busy, $sformatf("SPI still busy after %0d status reads", polls));
        bus_access(spi_addr(SPI_RXD_OFS), 1'b0, '0, '0);
        check_value("received byte", 32'(card_tx), last_rdata);
        check_value("card captured byte", 32'(tx_byte), 32'(card_rx));
        check_value("card bit count", 8, card_bits);
        bus_access(spi_addr(SPI_CTRL_OFS), 1'b1, 4'hF, 32'h1);
        check_value("ss after deselect", 1, 32'(spi_ss_o));
    endtask

    task automatic unmapped_access();
        bus_access(32'hC000_0008, 1'b1, 4'hF, random_bits(32));
        check_value("unmapped write latency", 2, last_latency);
        bus_access(32'hC000_0008, 1'b0, '0, '0);
        check_value("unmapped read latency", 2, last_latency);
        check_value("unmapped read data", 0, last_rdata);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        open_test("reset_state");
        reset_state();
        close_test();
        open_test("timer_access");
        timer_access();
        close_test();
        open_test("irq_lines");
        irq_lines();
        close_test();
        open_test("spi_transfer");
        spi_transfer();
        close_test();
        open_test("unmapped_access");
        unmapped_access();
        close_test();
        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/dev_subsystem.sv ====
`timescale 1ns/1ps

module dev_subsystem import dev_pkg::*; #(
    parameter int RST_STRETCH = 8,      // Reset stretch length in cycles
    parameter int SPI_CLK_DIV = 4       // System clocks per SCK period
) (
    input  logic   clk,
    input  logic   usr_reset,
    // Device bus from the core
    input  logic   dev_strobe_i,
    input  xword_t dev_addr_i,
    input  logic   dev_we_i,
    input  xbe_t   dev_be_i,
    input  xword_t dev_din_i,
    output xword_t dev_dout_o,
    output logic   dev_ready_o,
    // SD card
    output logic   spi_mosi_o,
    input  logic   spi_miso_i,
    output logic   spi_sck_o,
    output logic   spi_ss_o,
    // Core-local interrupts
    output logic   tmr_irq_o,
    output logic   sft_irq_o
);

    logic      rst;
    logic      spi_strobe, spi_ready;
    xword_t    spi_dout;
    logic      clint_strobe, clint_ready;
    xword_t    clint_dout;

    // AXI4-Lite link between bridge and SPI registers
    axi_addr_t axi_awaddr, axi_araddr;
    logic      axi_awvalid, axi_awready, axi_wvalid, axi_wready;
    logic      axi_bvalid, axi_bready, axi_arvalid, axi_arready;
    logic      axi_rvalid, axi_rready;
    xword_t    axi_wdata, axi_rdata;
    xbe_t      axi_wstrb;
    axi_resp_t axi_bresp, axi_rresp;

    dev_bus_ctrl #(.RST_STRETCH(RST_STRETCH)) u_bus_ctrl (
        .clk(clk), .usr_reset(usr_reset),
        .dev_strobe_i(dev_strobe_i), .dev_addr_i(dev_addr_i),
        .spi_ready_i(spi_ready), .spi_dout_i(spi_dout),
        .clint_ready_i(clint_ready), .clint_dout_i(clint_dout),
        .rst_o(rst), .spi_strobe_o(spi_strobe), .clint_strobe_o(clint_strobe),
        .dev_dout_o(dev_dout_o), .dev_ready_o(dev_ready_o)
    );

    core2axi_bridge u_bridge (
        .clk(clk), .rst_i(rst),
        .strobe_i(spi_strobe), .addr_i(dev_addr_i), .we_i(dev_we_i),
        .be_i(dev_be_i), .din_i(dev_din_i), .ready_o(spi_ready), .dout_o(spi_dout),
        .m_axi_awaddr_o(axi_awaddr), .m_axi_awvalid_o(axi_awvalid),
        .m_axi_awready_i(axi_awready), .m_axi_wdata_o(axi_wdata),
        .m_axi_wstrb_o(axi_wstrb), .m_axi_wvalid_o(axi_wvalid),
        .m_axi_wready_i(axi_wready), .m_axi_bresp_i(axi_bresp),
        .m_axi_bvalid_i(axi_bvalid), .m_axi_bready_o(axi_bready),
        .m_axi_araddr_o(axi_araddr), .m_axi_arvalid_o(axi_arvalid),
        .m_axi_arready_i(axi_arready), .m_axi_rdata_i(axi_rdata),
        .m_axi_rresp_i(axi_rresp), .m_axi_rvalid_i(axi_rvalid),
        .m_axi_rready_o(axi_rready)
    );

    spi_axil_regs #(.SPI_CLK_DIV(SPI_CLK_DIV)) u_spi (
        .clk(clk), .rst_i(rst),
        .s_axi_awaddr_i(axi_awaddr), .s_axi_awvalid_i(axi_awvalid),
        .s_axi_awready_o(axi_awready), .s_axi_wdata_i(axi_wdata),
        .s_axi_wstrb_i(axi_wstrb), .s_axi_wvalid_i(axi_wvalid),
        .s_axi_wready_o(axi_wready), .s_axi_bresp_o(axi_bresp),
        .s_axi_bvalid_o(axi_bvalid), .s_axi_bready_i(axi_bready),
        .s_axi_araddr_i(axi_araddr), .s_axi_arvalid_i(axi_arvalid),
        .s_axi_arready_o(axi_arready), .s_axi_rdata_o(axi_rdata),
        .s_axi_rresp_o(axi_rresp), .s_axi_rvalid_o(axi_rvalid),
        .s_axi_rready_i(axi_rready),
        .spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i),
        .spi_sck_o(spi_sck_o), .spi_ss_o(spi_ss_o)
    );

    clint_timer u_clint (
        .clk(clk), .rst_i(rst),
        .strobe_i(clint_strobe), .addr_i(dev_addr_i), .we_i(dev_we_i),
        .be_i(dev_be_i), .din_i(dev_din_i),
        .dout_o(clint_dout), .ready_o(clint_ready),
        .tmr_irq_o(tmr_irq_o), .sft_irq_o(sft_irq_o)
    );

endmodule

// ==== verilog/dev_bus_ctrl.sv ====
`timescale 1ns/1ps

module dev_bus_ctrl import dev_pkg::*; #(
    parameter int RST_STRETCH = 8
) (
    input  logic   clk,
    input  logic   usr_reset,
    input  logic   dev_strobe_i,
    input  xword_t dev_addr_i,
    input  logic   spi_ready_i,
    input  xword_t spi_dout_i,
    input  logic   clint_ready_i,
    input  xword_t clint_dout_i,
    output logic   rst_o,
    output logic   spi_strobe_o,
    output logic   clint_strobe_o,
    output xword_t dev_dout_o,
    output logic   dev_ready_o
);

    logic [RST_STRETCH-1:0] rst_sr;     // Ones shift out after usr_reset drops
    logic [7:0]             region;
    logic                   sel_spi, sel_clint;
    logic                   own_spi_q, own_clint_q;
    logic                   none_ack_q; // Unmapped responder
    logic                   ready_d;
    xword_t                 dout_d;

    // --------------------
    // Reset stretcher
    // --------------------
    always_ff @(posedge clk) begin
        if (usr_reset)
            rst_sr <= '1;
        else
            rst_sr <= rst_sr << 1;
    end
    assign rst_o = rst_sr[RST_STRETCH-1];

    // --------------------
    // Region decode
    // --------------------
    assign region         = dev_addr_i[XLEN-1 -: 8];
    assign sel_spi        = (region == REGION_SPI);
    assign sel_clint      = (region == REGION_CLINT);
    assign spi_strobe_o   = dev_strobe_i & sel_spi;
    assign clint_strobe_o = dev_strobe_i & sel_clint;

    always_ff @(posedge clk) begin
        if (rst_o) begin
            own_spi_q   <= 1'b0;
            own_clint_q <= 1'b0;
            none_ack_q  <= 1'b0;
            dev_ready_o <= 1'b0;
        end else begin
            if (dev_strobe_i) begin             // Owner held until next strobe
                own_spi_q   <= sel_spi;
                own_clint_q <= sel_clint;
            end
            none_ack_q  <= dev_strobe_i & ~sel_spi & ~sel_clint;
            dev_ready_o <= ready_d;
        end
    end

    // --------------------
    // Response mux
    // --------------------
    assign ready_d = (own_spi_q & spi_ready_i) | (own_clint_q & clint_ready_i) | none_ack_q;
    assign dout_d  = own_spi_q   ? spi_dout_i   :
                     own_clint_q ? clint_dout_i : '0;   // Unmapped reads zero

    always_ff @(posedge clk) begin
        if (ready_d)
            dev_dout_o <= dout_d;
    end

endmodule

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer import dev_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   strobe_i,
    input  xword_t addr_i,
    input  logic   we_i,
    input  xbe_t   be_i,
    input  xword_t din_i,
    output xword_t dout_o,
    output logic   ready_o,
    output logic   tmr_irq_o,
    output logic   sft_irq_o
);

    logic [63:0] mtime_q, mtimecmp_q;
    logic        msip_q;
    logic [11:0] ofs;
    logic        wr;
    logic [5:0]  cmp_base;                  // Bit offset of addressed mtimecmp half

    assign ofs       = addr_i[11:0];
    assign wr        = strobe_i & we_i;
    assign cmp_base  = (ofs == CLINT_CMP_HI_OFS) ? 6'd32 : 6'd0;
    assign sft_irq_o = msip_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;               // No timer interrupt until programmed
            msip_q     <= 1'b0;
            ready_o    <= 1'b0;
            tmr_irq_o  <= 1'b0;
        end else begin
            ready_o   <= strobe_i;          // Every access answered next cycle
            tmr_irq_o <= (mtime_q >= mtimecmp_q);

            // mtime counts unless a half is written
            if (wr && ofs == CLINT_TIME_LO_OFS)
                mtime_q <= {mtime_q[63:32], din_i};
            else if (wr && ofs == CLINT_TIME_HI_OFS)
                mtime_q <= {din_i, mtime_q[31:0]};
            else
                mtime_q <= mtime_q + 64'd1;

            if (wr && (ofs == CLINT_CMP_LO_OFS || ofs == CLINT_CMP_HI_OFS)) begin
                for (int i = 0; i < XLEN / 8; i++) begin
                    if (be_i[i])
                        mtimecmp_q[cmp_base + 8 * i +: 8] <= din_i[8 * i +: 8];
                end
            end

            if (wr && ofs == CLINT_MSIP_OFS && be_i[0])
                msip_q <= din_i[0];
        end
    end

    // --------------------
    // Read data
    // --------------------
    always_ff @(posedge clk) begin
        if (strobe_i) begin
            case (ofs)
                CLINT_MSIP_OFS:    dout_o <= {31'b0, msip_q};
                CLINT_CMP_LO_OFS:  dout_o <= mtimecmp_q[31:0];
                CLINT_CMP_HI_OFS:  dout_o <= mtimecmp_q[63:32];
                CLINT_TIME_LO_OFS: dout_o <= mtime_q[31:0];
                CLINT_TIME_HI_OFS: dout_o <= mtime_q[63:32];
                default:           dout_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/core2axi_bridge.sv ====
`timescale 1ns/1ps

module core2axi_bridge import dev_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    // Device bus target side
    input  logic      strobe_i,
    input  xword_t    addr_i,
    input  logic      we_i,
    input  xbe_t      be_i,
    input  xword_t    din_i,
    output logic      ready_o,
    output xword_t    dout_o,
    // AXI4-Lite master side
    output axi_addr_t m_axi_awaddr_o,
    output logic      m_axi_awvalid_o,
    input  logic      m_axi_awready_i,
    output xword_t    m_axi_wdata_o,
    output xbe_t      m_axi_wstrb_o,
    output logic      m_axi_wvalid_o,
    input  logic      m_axi_wready_i,
    input  axi_resp_t m_axi_bresp_i,        // Always OKAY
    input  logic      m_axi_bvalid_i,
    output logic      m_axi_bready_o,
    output axi_addr_t m_axi_araddr_o,
    output logic      m_axi_arvalid_o,
    input  logic      m_axi_arready_i,
    input  xword_t    m_axi_rdata_i,
    input  axi_resp_t m_axi_rresp_i,        // Always OKAY
    input  logic      m_axi_rvalid_i,
    output logic      m_axi_rready_o
);

    bridge_state_t state_q, state_d;
    axi_addr_t     addr_q;
    xword_t        wdata_q, rdata_q;
    xbe_t          wstrb_q;
    logic          aw_done_q, w_done_q;   // Per-channel handshake seen
    logic          aw_hs, w_hs;

    // Request fields held for the whole transaction
    assign m_axi_awaddr_o = addr_q;
    assign m_axi_araddr_o = addr_q;
    assign m_axi_wdata_o  = wdata_q;
    assign m_axi_wstrb_o  = wstrb_q;

    assign m_axi_awvalid_o = (state_q == WR_ADDR_DATA) & ~aw_done_q;
    assign m_axi_wvalid_o  = (state_q == WR_ADDR_DATA) & ~w_done_q;
    assign m_axi_bready_o  = (state_q == WR_RESP);
    assign m_axi_arvalid_o = (state_q == RD_ADDR);
    assign m_axi_rready_o  = (state_q == RD_DATA);

    assign aw_hs   = m_axi_awvalid_o & m_axi_awready_i;
    assign w_hs    = m_axi_wvalid_o & m_axi_wready_i;
    assign ready_o = (state_q == DONE);     // One-cycle pulse
    assign dout_o  = rdata_q;

    // --------------------
    // FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (strobe_i)
                    state_d = we_i ? WR_ADDR_DATA : RD_ADDR;
            WR_ADDR_DATA:
                if ((aw_done_q | aw_hs) & (w_done_q | w_hs))
                    state_d = WR_RESP;
            WR_RESP:
                if (m_axi_bvalid_i)
                    state_d = DONE;
            RD_ADDR:
                if (m_axi_arready_i)
                    state_d = RD_DATA;
            RD_DATA:
                if (m_axi_rvalid_i)
                    state_d = DONE;
            default: state_d = IDLE;        // DONE back to idle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q | aw_hs;
                w_done_q  <= w_done_q | w_hs;
            end
        end
    end

    // Latch request and capture read data
    always_ff @(posedge clk) begin
        if (state_q == IDLE && strobe_i) begin
            addr_q  <= addr_i[AXI_ADDR_W-1:0];
            wdata_q <= din_i;
            wstrb_q <= be_i;
            rdata_q <= '0;                  // Writes answer zero
        end else if (state_q == RD_DATA && m_axi_rvalid_i) begin
            rdata_q <= m_axi_rdata_i;
        end
    end

endmodule

// ==== verilog/spi_axil_regs.sv ====
`timescale 1ns/1ps

module spi_axil_regs import dev_pkg::*; #(
    parameter int SPI_CLK_DIV = 4
) (
    input  logic      clk,
    input  logic      rst_i,
    // AXI4-Lite target
    input  axi_addr_t s_axi_awaddr_i,
    input  logic      s_axi_awvalid_i,
    output logic      s_axi_awready_o,
    input  xword_t    s_axi_wdata_i,
    input  xbe_t      s_axi_wstrb_i,
    input  logic      s_axi_wvalid_i,
    output logic      s_axi_wready_o,
    output axi_resp_t s_axi_bresp_o,
    output logic      s_axi_bvalid_o,
    input  logic      s_axi_bready_i,
    input  axi_addr_t s_axi_araddr_i,
    input  logic      s_axi_arvalid_i,
    output logic      s_axi_arready_o,
    output xword_t    s_axi_rdata_o,
    output axi_resp_t s_axi_rresp_o,
    output logic      s_axi_rvalid_o,
    input  logic      s_axi_rready_i,
    // SD card pins
    output logic      spi_mosi_o,
    input  logic      spi_miso_i,
    output logic      spi_sck_o,
    output logic      spi_ss_o
);

    logic        wr_hs, rd_hs;
    logic [11:0] wofs, rofs;
    logic        start, busy, done;
    logic [7:0]  rx_byte;
    logic [7:0]  rxd_q;                 // Last received byte

    assign wofs = 12'(s_axi_awaddr_i);
    assign rofs = 12'(s_axi_araddr_i);

    // --------------------
    // Handshakes
    // --------------------
    // AW and W taken together, only while no B is pending
    assign wr_hs           = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_bvalid_o;
    assign s_axi_awready_o = wr_hs;
    assign s_axi_wready_o  = wr_hs;
    assign s_axi_arready_o = ~s_axi_rvalid_o;
    assign rd_hs           = s_axi_arvalid_i & s_axi_arready_o;
    assign s_axi_bresp_o   = '0;        // OKAY
    assign s_axi_rresp_o   = '0;

    // Transmit write launches only when idle
    assign start = wr_hs & (wofs == SPI_TXD_OFS) & s_axi_wstrb_i[0] & ~busy;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s_axi_bvalid_o <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
            spi_ss_o       <= 1'b1;     // Card deselected
        end else begin
            if (wr_hs)
                s_axi_bvalid_o <= 1'b1;
            else if (s_axi_bready_i)
                s_axi_bvalid_o <= 1'b0;
            if (rd_hs)
                s_axi_rvalid_o <= 1'b1;
            else if (s_axi_rready_i)
                s_axi_rvalid_o <= 1'b0;
            if (wr_hs && wofs == SPI_CTRL_OFS && s_axi_wstrb_i[0])
                spi_ss_o <= s_axi_wdata_i[0];
        end
    end

    // --------------------
    // Read data and RX capture
    // --------------------
    always_ff @(posedge clk) begin
        if (done)
            rxd_q <= rx_byte;
        if (rd_hs) begin
            case (rofs)
                SPI_CTRL_OFS: s_axi_rdata_o <= {31'b0, spi_ss_o};
                SPI_STAT_OFS: s_axi_rdata_o <= {31'b0, busy};
                SPI_RXD_OFS:  s_axi_rdata_o <= {24'b0, rxd_q};
                default:      s_axi_rdata_o <= '0;
            endcase
        end
    end

    spi_shifter #(.SPI_CLK_DIV(SPI_CLK_DIV)) u_shifter (
        .clk(clk), .rst_i(rst_i),
        .start_i(start), .tx_byte_i(s_axi_wdata_i[7:0]), .miso_i(spi_miso_i),
        .busy_o(busy), .done_o(done), .rx_byte_o(rx_byte),
        .sck_o(spi_sck_o), .mosi_o(spi_mosi_o)
    );

endmodule

// ==== verilog/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter #(
    parameter int SPI_CLK_DIV = 4           // Even, at least 2
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic [7:0] tx_byte_i,
    input  logic       miso_i,
    output logic       busy_o,
    output logic       done_o,
    output logic [7:0] rx_byte_o,
    output logic       sck_o,
    output logic       mosi_o
);

    localparam int HALF  = SPI_CLK_DIV / 2; // Cycles per SCK phase
    localparam int CNT_W = $clog2(SPI_CLK_DIV);

    logic [CNT_W-1:0] div_q;
    logic [2:0]       bit_q;
    logic [7:0]       tx_q;
    logic             tick;                 // SCK toggles this cycle

    assign tick   = busy_o & (div_q == CNT_W'(HALF - 1));
    assign mosi_o = tx_q[7];                // MSB valid before first rise

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            sck_o  <= 1'b0;
            div_q  <= '0;
            bit_q  <= '0;
            tx_q   <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !busy_o) begin
                busy_o <= 1'b1;
                tx_q   <= tx_byte_i;
                div_q  <= '0;
                bit_q  <= '0;
            end else if (busy_o) begin
                div_q <= tick ? '0 : div_q + 1'b1;
                if (tick) begin
                    sck_o <= ~sck_o;
                    if (sck_o) begin        // Falling edge, next bit out
                        tx_q  <= {tx_q[6:0], 1'b0};
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7) begin
                            busy_o <= 1'b0;
                            done_o <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // MISO sampled on rising SCK
    always_ff @(posedge clk) begin
        if (tick && !sck_o)
            rx_byte_o <= {rx_byte_o[6:0], miso_i};
    end

endmodule

// ==== verilog/dev_pkg.sv ====
package dev_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int XLEN       = 32;                 // Device bus data/address width
    localparam int AXI_ADDR_W = 7;                  // AXI4-Lite address width

    typedef logic [XLEN-1:0]       xword_t;         // Device bus word
    typedef logic [XLEN/8-1:0]     xbe_t;           // Byte enables
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;      // AXI4-Lite address
    typedef logic [1:0]            axi_resp_t;      // AXI response code

    // Address top byte of each device region
    localparam logic [7:0] REGION_SPI   = 8'hC2;
    localparam logic [7:0] REGION_CLINT = 8'hC4;

    // SPI register map
    localparam logic [11:0] SPI_CTRL_OFS = 12'h000; // Bit 0 = slave select, active low
    localparam logic [11:0] SPI_STAT_OFS = 12'h004; // Bit 0 = busy
    localparam logic [11:0] SPI_TXD_OFS  = 12'h008; // Write starts a transfer
    localparam logic [11:0] SPI_RXD_OFS  = 12'h00C; // Last received byte

    // Timer register map
    localparam logic [11:0] CLINT_MSIP_OFS    = 12'h000;
    localparam logic [11:0] CLINT_CMP_LO_OFS  = 12'h008;
    localparam logic [11:0] CLINT_CMP_HI_OFS  = 12'h00C;
    localparam logic [11:0] CLINT_TIME_LO_OFS = 12'h010;
    localparam logic [11:0] CLINT_TIME_HI_OFS = 12'h014;

    // Bridge FSM
    typedef enum logic [2:0] {
        IDLE, WR_ADDR_DATA, WR_RESP, RD_ADDR, RD_DATA, DONE
    } bridge_state_t;

endpackage
